// ==== common/oam_dma_pkg.sv ====
package oam_dma_pkg;

	// one master's request, single-cycle strobes
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} mem_req_t;

	typedef enum logic [2:0] {
		tgt_vram,
		tgt_ext,
		tgt_oam,
		tgt_reg,
		tgt_none
	} mem_target_e;

	typedef enum logic [1:0] {
		dma_idle,
		dma_start,
		dma_xfer
	} dma_state_e;

	localparam logic [15:0] DMA_REG_ADDR = 16'hFF46;
	localparam logic [15:0] OAM_BASE     = 16'hFE00;
	localparam logic [15:0] VRAM_BASE    = 16'h8000;
	localparam logic [15:0] WRAM_BASE    = 16'hC000;

	localparam int OAM_BYTES = 160;

	// address map of the shared buses
	function automatic mem_target_e addr_target(input logic [15:0] addr);
		mem_target_e tgt;
		if (addr[15:13] == VRAM_BASE[15:13]) begin
			tgt = tgt_vram;
		end else if (addr == DMA_REG_ADDR) begin
			tgt = tgt_reg;
		end else if (addr >= OAM_BASE && addr < OAM_BASE + 16'(OAM_BYTES)) begin
			tgt = tgt_oam;
		end else if (addr >= OAM_BASE) begin
			tgt = tgt_none; // unused OAM tail and I/O page
		end else begin
			tgt = tgt_ext; // external bus, only work RAM answers
		end
		return tgt;
	endfunction

endpackage

// ==== dma/oam_dma.sv ====
`timescale 1ns/1ps

module oam_dma
	import oam_dma_pkg::*;
#(
	parameter int OAM_BYTES = oam_dma_pkg::OAM_BYTES
) (
	input  logic       clk,
	input  logic       rst_n,
	input  mem_req_t   reg_req,
	output logic [7:0] reg_rdata,
	input  logic [7:0] src_rdata,
	output mem_req_t   dma_src_req,
	output mem_req_t   dma_oam_req,
	output logic       dma_run
);

	localparam logic [7:0] LAST_CNT = 8'(OAM_BYTES);

	dma_state_e state;
	dma_state_e state_nxt;

	logic [7:0] page;
	logic [7:0] cnt;
	logic [7:0] oam_idx;
	logic       oam_vld;
	logic       page_wr;
	logic       src_rd;

	assign page_wr = reg_req.wr && (reg_req.addr == DMA_REG_ADDR);

	// source reads only for run cycles 0 .. OAM_BYTES-1
	assign src_rd  = (state == dma_xfer) && (cnt < LAST_CNT);
	assign dma_run = (state == dma_xfer);

	always_comb begin
		state_nxt = state;
		case (state)
			dma_idle: begin
				if (page_wr) begin
					state_nxt = dma_start;
				end
			end
			dma_start: begin
				if (!page_wr) begin
					state_nxt = dma_xfer; // one cycle of start delay
				end
			end
			dma_xfer: begin
				if (page_wr) begin
					state_nxt = dma_start; // restart with the new page
				end else if (cnt == LAST_CNT) begin
					state_nxt = dma_idle; // last OAM write done
				end
			end
			default: begin
				state_nxt = dma_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dma_idle;
			page  <= 8'h00;
			cnt   <= 8'h00;
		end else begin
			state <= state_nxt;
			if (page_wr) begin
				page <= reg_req.wdata;
			end
			if (state_nxt != dma_xfer) begin
				cnt <= 8'h00;
			end else if (state == dma_xfer) begin
				cnt <= cnt + 8'h01;
			end
		end
	end

	// second stage, byte of the previous read goes to OAM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			oam_vld <= 1'b0;
			oam_idx <= 8'h00;
		end else begin
			oam_vld <= src_rd && !page_wr; // a restart drops the byte in flight
			oam_idx <= cnt;
		end
	end

	// page register read port, one cycle like the memories
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_rdata <= 8'h00;
		end else if (reg_req.rd) begin
			reg_rdata <= page;
		end
	end

	always_comb begin
		dma_src_req       = '0;
		dma_src_req.addr  = {page, cnt};
		dma_src_req.rd    = src_rd;

		dma_oam_req       = '0;
		dma_oam_req.addr  = OAM_BASE + {8'h00, oam_idx};
		dma_oam_req.wdata = src_rdata;
		dma_oam_req.wr    = oam_vld;
	end

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
	import oam_dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mem_req_t   cpu_req,
	input  mem_req_t   dma_src_req,
	input  mem_req_t   dma_oam_req,
	input  logic       dma_run,
	output mem_req_t   vram_req,
	output mem_req_t   ext_req,
	output mem_req_t   oam_req,
	output mem_req_t   reg_req,
	input  logic [7:0] vram_rdata,
	input  logic [7:0] ext_rdata,
	input  logic [7:0] oam_rdata,
	input  logic [7:0] reg_rdata,
	output logic [7:0] src_rdata,
	output logic [7:0] cpu_rdata
);

	mem_target_e cpu_tgt;
	mem_target_e dma_tgt;
	mem_target_e rd_tgt;

	mem_req_t   cpu_pass;
	logic       cpu_blk;
	logic       rd_pend;
	logic       rd_blk;
	logic [7:0] rd_data;
	logic [7:0] hold_q;

	assign cpu_tgt = addr_target(cpu_req.addr);

	// DMA source is video RAM or else the external bus
	assign dma_tgt = (addr_target(dma_src_req.addr) == tgt_vram) ? tgt_vram : tgt_ext;

	assign cpu_blk = dma_run && ((cpu_tgt == tgt_oam) || (cpu_tgt == dma_tgt));

	always_comb begin
		cpu_pass = cpu_req;
		if (cpu_blk) begin
			cpu_pass.rd = 1'b0; // dropped, DMA owns the target
			cpu_pass.wr = 1'b0;
		end
	end

	always_comb begin
		vram_req = '0;
		ext_req  = '0;
		oam_req  = '0;
		reg_req  = '0;
		if (dma_run && dma_tgt == tgt_vram) begin
			vram_req = dma_src_req;
		end else if (cpu_tgt == tgt_vram) begin
			vram_req = cpu_pass;
		end
		if (dma_run && dma_tgt == tgt_ext) begin
			ext_req = dma_src_req;
		end else if (cpu_tgt == tgt_ext) begin
			ext_req = cpu_pass;
		end
		if (dma_run) begin
			oam_req = dma_oam_req;
		end else if (cpu_tgt == tgt_oam) begin
			oam_req = cpu_pass;
		end
		if (cpu_tgt == tgt_reg) begin
			reg_req = cpu_req; // never blocked so a restart gets through
		end
	end

	// page is stable across a run, so the live source target is valid
	assign src_rdata = (dma_tgt == tgt_vram) ? vram_rdata : ext_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend <= 1'b0;
			rd_blk  <= 1'b0;
			rd_tgt  <= tgt_none;
		end else begin
			rd_pend <= cpu_req.rd;
			if (cpu_req.rd) begin
				rd_blk <= cpu_blk;
				rd_tgt <= cpu_tgt;
			end
		end
	end

	always_comb begin
		case (rd_tgt)
			tgt_vram: rd_data = vram_rdata;
			tgt_ext:  rd_data = ext_rdata;
			tgt_oam:  rd_data = oam_rdata;
			tgt_reg:  rd_data = reg_rdata;
			default:  rd_data = 8'hFF;
		endcase
		if (rd_blk) begin
			rd_data = 8'hFF;
		end
	end

	// keeps the last read value while the DMA reuses the memories
	always_ff @(posedge clk) begin
		hold_q <= cpu_rdata;
	end

	assign cpu_rdata = rd_pend ? rd_data : hold_q;

endmodule

// ==== src/oam_ram.sv ====
`timescale 1ns/1ps

module oam_ram
	import oam_dma_pkg::*;
#(
	parameter int OAM_BYTES = oam_dma_pkg::OAM_BYTES
) (
	input  logic       clk,
	input  logic       rst_n,
	input  mem_req_t   oam_req,
	output logic [7:0] oam_rdata
);

	localparam int IW = $clog2(OAM_BYTES);

	logic [7:0]  mem [OAM_BYTES];
	logic [15:0] idx;
	logic        in_range;

	assign idx      = oam_req.addr - OAM_BASE;
	assign in_range = (idx < 16'(OAM_BYTES));

	always_ff @(posedge clk) begin
		if (oam_req.wr && in_range) begin
			mem[idx[IW-1:0]] <= oam_req.wdata;
		end
	end

	// registered read, out of range reads float high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			oam_rdata <= 8'hFF;
		end else if (oam_req.rd) begin
			if (in_range) begin
				oam_rdata <= mem[idx[IW-1:0]];
			end else begin
				oam_rdata <= 8'hFF;
			end
		end
	end

endmodule

// ==== src/mem_bank.sv ====
`timescale 1ns/1ps

module mem_bank
	import oam_dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mem_req_t   vram_req,
	input  mem_req_t   ext_req,
	output logic [7:0] vram_rdata,
	output logic [7:0] ext_rdata
);

	logic [7:0] vram [8192];
	logic [7:0] wram [8192];
	logic       vram_sel;
	logic       wram_sel;

	assign vram_sel = (vram_req.addr[15:13] == VRAM_BASE[15:13]);
	assign wram_sel = (ext_req.addr[15:13] == WRAM_BASE[15:13]); // only work RAM on ext bus

	// video RAM port
	always_ff @(posedge clk) begin
		if (vram_req.wr && vram_sel) begin
			vram[vram_req.addr[12:0]] <= vram_req.wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vram_rdata <= 8'hFF;
		end else if (vram_req.rd) begin
			vram_rdata <= vram[vram_req.addr[12:0]];
		end
	end

	// external bus port, runs alongside the video RAM port
	always_ff @(posedge clk) begin
		if (ext_req.wr && wram_sel) begin
			wram[ext_req.addr[12:0]] <= ext_req.wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ext_rdata <= 8'hFF;
		end else if (ext_req.rd) begin
			if (wram_sel) begin
				ext_rdata <= wram[ext_req.addr[12:0]];
			end else begin
				ext_rdata <= 8'hFF; // open bus
			end
		end
	end

endmodule

// ==== src/oam_dma_top.sv ====
`timescale 1ns/1ps

module oam_dma_top
	import oam_dma_pkg::*;
#(
	parameter int OAM_BYTES = oam_dma_pkg::OAM_BYTES
) (
	input  logic       clk,
	input  logic       rst_n,
	input  mem_req_t   cpu_req,
	output logic [7:0] cpu_rdata,
	output logic       dma_run
);

	mem_req_t   dma_src_req;
	mem_req_t   dma_oam_req;
	mem_req_t   vram_req;
	mem_req_t   ext_req;
	mem_req_t   oam_req;
	mem_req_t   reg_req;
	logic [7:0] vram_rdata;
	logic [7:0] ext_rdata;
	logic [7:0] oam_rdata;
	logic [7:0] reg_rdata;
	logic [7:0] src_rdata;

	oam_dma #(
		.OAM_BYTES (OAM_BYTES)
	) dma0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.reg_req     (reg_req),
		.reg_rdata   (reg_rdata),
		.src_rdata   (src_rdata),
		.dma_src_req (dma_src_req),
		.dma_oam_req (dma_oam_req),
		.dma_run     (dma_run)
	);

	bus_arbiter arb0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.dma_src_req (dma_src_req),
		.dma_oam_req (dma_oam_req),
		.dma_run     (dma_run),
		.vram_req    (vram_req),
		.ext_req     (ext_req),
		.oam_req     (oam_req),
		.reg_req     (reg_req),
		.vram_rdata  (vram_rdata),
		.ext_rdata   (ext_rdata),
		.oam_rdata   (oam_rdata),
		.reg_rdata   (reg_rdata),
		.src_rdata   (src_rdata),
		.cpu_rdata   (cpu_rdata)
	);

	oam_ram #(
		.OAM_BYTES (OAM_BYTES)
	) oam0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.oam_req   (oam_req),
		.oam_rdata (oam_rdata)
	);

	mem_bank mem0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.vram_req   (vram_req),
		.ext_req    (ext_req),
		.vram_rdata (vram_rdata),
		.ext_rdata  (ext_rdata)
	);

endmodule

// ==== verification/oam_dma_properties.sv ====
`timescale 1ns/1ps

module oam_dma_properties
	import oam_dma_pkg::*;
#(
	parameter int OAM_BYTES = oam_dma_pkg::OAM_BYTES
) (
	input logic     clk,
	input logic     rst_n,
	input mem_req_t reg_req,
	input mem_req_t dma_src_req,
	input mem_req_t dma_oam_req,
	input logic     dma_run
);

	logic [8:0] run_len;
	logic       restarted;
	int         prop_errors = 0;

	// length of the current run and whether a page write cut it short
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_len   <= '0;
			restarted <= 1'b0;
		end else if (dma_run) begin
			run_len <= run_len + 9'd1;
			if (reg_req.wr && reg_req.addr == DMA_REG_ADDR) begin
				restarted <= 1'b1;
			end
		end else begin
			run_len   <= '0;
			restarted <= 1'b0;
		end
	end

	run_len_chk: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(dma_run) && !restarted |-> run_len == 9'(OAM_BYTES + 1))
		else begin
			prop_errors++;
			$error("dma_run high for %0d cycles", run_len);
		end

	strobe_chk: assert property (@(posedge clk) disable iff (!rst_n)
		!dma_run |-> !dma_src_req.rd && !dma_oam_req.wr)
		else begin
			prop_errors++;
			$error("DMA strobe outside a run");
		end

	// OAM index lags the source index by one byte
	idx_chk: assert property (@(posedge clk) disable iff (!rst_n)
		dma_oam_req.wr |-> dma_src_req.addr[7:0] == dma_oam_req.addr[7:0] + 8'd1)
		else begin
			prop_errors++;
			$error("OAM index %0d does not trail source index %0d",
				dma_oam_req.addr[7:0], dma_src_req.addr[7:0]);
		end

endmodule

bind oam_dma oam_dma_properties #(
	.OAM_BYTES (OAM_BYTES)
) props0 (
	.clk         (clk),
	.rst_n       (rst_n),
	.reg_req     (reg_req),
	.dma_src_req (dma_src_req),
	.dma_oam_req (dma_oam_req),
	.dma_run     (dma_run)
);

// ==== verification/oam_dma_tb.sv ====
`timescale 1ns/1ps

module oam_dma_tb
	import oam_dma_pkg::*;
();

	localparam int N_RAND   = 16;
	localparam int N_UNMAP  = 4;
	localparam int OP_CYC   = 2; // one CPU access
	localparam int PAGE_CYC = OP_CYC * OAM_BYTES;
	localparam int RUN_CYC  = OAM_BYTES + 4;
	localparam int TEST_CYC = 2 * OP_CYC * (3 * N_RAND + 5 * N_UNMAP) + 8 * PAGE_CYC
		+ 6 * RUN_CYC + 64;
	localparam int TIMEOUT_CYC = TEST_CYC + TEST_CYC / 2;

	logic       clk;
	logic       rst_n;
	mem_req_t   cpu_req;
	logic [7:0] cpu_rdata;
	logic       dma_run;

	// shadow copies of the memories
	logic [7:0]  vram_m [8192];
	logic [7:0]  wram_m [8192];
	logic [7:0]  oam_m [OAM_BYTES];
	logic [7:0]  page_m;
	logic [31:0] rng = 32'hcb6cd065;
	int          errors = 0;
	int          cycles = 0;

	oam_dma_top #(
		.OAM_BYTES (OAM_BYTES)
	) dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_req   (cpu_req),
		.cpu_rdata (cpu_rdata),
		.dma_run   (dma_run)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// console address map as seen by the CPU
	function automatic logic [7:0] model_read(input logic [15:0] addr);
		if (addr inside {[16'h8000:16'h9FFF]}) return vram_m[addr[12:0]];
		if (addr inside {[16'hC000:16'hDFFF]}) return wram_m[addr[12:0]];
		if (addr >= OAM_BASE && addr < OAM_BASE + OAM_BYTES) return oam_m[addr - OAM_BASE];
		if (addr == DMA_REG_ADDR) return page_m;
		return 8'hFF; // open bus
	endfunction

	function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr inside {[16'h8000:16'h9FFF]}) vram_m[addr[12:0]] = data;
		else if (addr inside {[16'hC000:16'hDFFF]}) wram_m[addr[12:0]] = data;
		else if (addr >= OAM_BASE && addr < OAM_BASE + OAM_BYTES) oam_m[addr - OAM_BASE] = data;
	endfunction

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_req <= mem_req_t'{addr: addr, wdata: data, rd: 1'b0, wr: 1'b1};
		@(posedge clk);
		cpu_req <= '0;
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [7:0] expected);
		@(posedge clk);
		cpu_req <= mem_req_t'{addr: addr, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
		@(posedge clk);
		cpu_req <= '0;
		@(negedge clk); // data registered at the last edge
		assert (cpu_rdata === expected) else begin
			errors++;
			$display("FAILED at %0t: read of %h returned %h, expected %h",
				$time, addr, cpu_rdata, expected);
		end
	endtask

	task automatic wait_run(input logic level);
		int n = 0;
		@(negedge clk);
		while (dma_run !== level && n < 2 * RUN_CYC) begin
			n++;
			@(negedge clk);
		end
		assert (dma_run === level) else begin
			errors++;
			$display("dma_run did not go to %0b within %0d cycles", level, 2 * RUN_CYC);
		end
	endtask

	task automatic fill_page(input logic [7:0] page);
		logic [7:0] data;
		for (int k = 0; k < OAM_BYTES; k++) begin
			data = 8'(next_rand());
			bus_write({page, 8'(k)}, data);
			model_write({page, 8'(k)}, data);
		end
	endtask

	task automatic start_dma(input logic [7:0] page);
		bus_write(DMA_REG_ADDR, page);
		page_m = page;
	endtask

	// OAM must hold the source page, register reads back the page
	task automatic check_copy(input logic [7:0] page);
		for (int k = 0; k < OAM_BYTES; k++) begin
			oam_m[k] = model_read({page, 8'(k)});
			check_read(OAM_BASE + 16'(k), oam_m[k]);
		end
		check_read(DMA_REG_ADDR, model_read(DMA_REG_ADDR));
	endtask

	task automatic mem_access();
		logic [15:0] addr_q [$];
		logic [7:0]  data;
		for (int i = 0; i < N_RAND; i++) begin
			addr_q.push_back(16'h8000 | 16'(next_rand() & 32'h1FFF));
			addr_q.push_back(16'hC000 | 16'(next_rand() & 32'h1FFF));
			addr_q.push_back(OAM_BASE + 16'(next_rand() % OAM_BYTES));
		end
		for (int i = 0; i < N_UNMAP; i++) begin
			addr_q.push_back(16'(next_rand() & 32'h7FFF)); // no cartridge
			addr_q.push_back(16'hA000 | 16'(next_rand() & 32'h1FFF));
			addr_q.push_back(16'hE000 + 16'(next_rand() % 32'h1E00));
			addr_q.push_back(16'hFEA0 + 16'(next_rand() % 32'h60)); // OAM tail
			addr_q.push_back(16'hFF00 + 16'(next_rand() & 32'h3F)); // stays below FF46
		end
		foreach (addr_q[i]) begin
			data = 8'(next_rand());
			bus_write(addr_q[i], data);
			model_write(addr_q[i], data);
		end
		foreach (addr_q[i]) begin
			check_read(addr_q[i], model_read(addr_q[i]));
		end
	endtask

	task automatic wram_transfer();
		fill_page(8'hC1);
		start_dma(8'hC1);
		wait_run(1'b1);
		wait_run(1'b0);
		check_copy(8'hC1);
	endtask

	task automatic vram_transfer();
		int run_len = 0;
		fill_page(8'h80);
		start_dma(8'h80);
		@(negedge clk);
		assert (dma_run === 1'b0) else begin
			errors++;
			$display("dma_run rose one edge after the register write");
		end
		@(negedge clk); // two edges after the write
		while (dma_run === 1'b1 && run_len < 2 * RUN_CYC) begin
			run_len++;
			@(negedge clk);
		end
		assert (run_len == OAM_BYTES + 1) else begin
			errors++;
			$display("FAILED at %0t: dma_run high for %0d cycles, expected %0d",
				$time, run_len, OAM_BYTES + 1);
		end
		wait_run(1'b0);
		check_copy(8'h80);
	endtask

	task automatic blocking_during_dma();
		start_dma(8'hC1); // work RAM source
		wait_run(1'b1);
		check_read(16'hC110, 8'hFF);
		check_read(OAM_BASE + 16'h0010, 8'hFF);
		bus_write(16'hC105, ~model_read(16'hC105)); // lost
		bus_write(OAM_BASE + 16'h0005, 8'hA5);
		bus_write(16'h8123, 8'h3C);
		model_write(16'h8123, 8'h3C);
		check_read(16'h8123, 8'h3C);
		wait_run(1'b0);
		check_copy(8'hC1);
		check_read(16'hC105, model_read(16'hC105));
		start_dma(8'h80); // video RAM source
		wait_run(1'b1);
		check_read(16'h8010, 8'hFF);
		check_read(OAM_BASE + 16'h0020, 8'hFF);
		bus_write(16'h8005, ~model_read(16'h8005));
		bus_write(16'hD234, 8'hC3);
		model_write(16'hD234, 8'hC3);
		check_read(16'hD234, 8'hC3);
		wait_run(1'b0);
		check_copy(8'h80);
		check_read(16'h8005, model_read(16'h8005));
	endtask

	task automatic restart_transfer();
		fill_page(8'hC3);
		start_dma(8'h80);
		wait_run(1'b1);
		repeat (40) @(posedge clk);
		start_dma(8'hC3); // new page mid-transfer
		wait_run(1'b1);
		wait_run(1'b0);
		check_copy(8'hC3);
	endtask

	initial begin
		clk     = 1'b0;
		rst_n   = 1'b0;
		cpu_req = '0;
		page_m  = 8'h00;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		mem_access();
		wram_transfer();
		vram_transfer();
		blocking_during_dma();
		restart_transfer();
		repeat (4) @(posedge clk);
		$display("check errors: %0d, assertion errors: %0d",
			errors, dut0.dma0.props0.prop_errors);
		if (errors == 0 && dut0.dma0.props0.prop_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
common/oam_dma_pkg.sv
dma/oam_dma.sv
src/bus_arbiter.sv
src/oam_ram.sv
src/mem_bank.sv
src/oam_dma_top.sv
verification/oam_dma_properties.sv
verification/oam_dma_tb.sv

// ==== Bender.yml ====
package:
  name: oam_dma

sources:
  - common/oam_dma_pkg.sv
  - dma/oam_dma.sv
  - src/bus_arbiter.sv
  - src/oam_ram.sv
  - src/mem_bank.sv
  - src/oam_dma_top.sv
  - target: test
    files:
      - verification/oam_dma_properties.sv
      - verification/oam_dma_tb.sv
